// ==== src.f ====
src/mv_pkg.sv
src/weight_feeder.sv
src/dot_lane.sv
src/score_argmax.sv
src/mv_score_top.sv
bench/mv_score_sva.sv
bench/mv_score_tb.sv

// ==== Makefile ====
# Verilator build for the matrix-vector scoring engine
# make lint   static checks on RTL and bench
# make sim    build, run, and grep the log for the pass line
# make clean  remove build products

TOP := mv_score_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP) -f src.f
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG) || \
		{ echo "Simulation did not pass, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/mv_score_tb.sv ====
// Testbench for the matrix-vector scoring engine
// Clock, reset, directed and random stimulus, reference model
// Result checks by immediate assertions, watchdog and verdict

`timescale 1ns/100ps
`default_nettype none

module mv_score_tb;

   import mv_pkg::*;

   localparam int LANES      = 8;
   localparam int CLK_PERIOD = 40;
   // Cycles from the edge that samples a run to result.valid
   localparam int LATENCY    = 6;
   localparam int STREAM_N   = 200;
   // Directed commands, idle gaps and drains, counted generously
   localparam int DIRECTED_N = 250;
   localparam int MARGIN     = 100;

   typedef logic [VEC_N-1:0][DATA_W-1:0] vec_t;

   // One expected result and the cycle its run was driven
   typedef struct packed {
      logic [ROW_W-1:0]  index;
      logic [DATA_W-1:0] score;
      logic [31:0]       cyc;
   } exp_result_t;

   logic    clk;
   logic    rst;
   cmd_t    cmd;
   result_t result;

   // Reference weight matrix
   vec_t        model_w [LANES];
   exp_result_t exp_q [$];

   // Monitor state
   exp_result_t head;
   logic        have_exp;
   logic [31:0] lat;
   logic [31:0] cycle_cnt = '0;

   // ====================
   // DUT and clock
   // ====================

   mv_score_top #(
      .LANES  (LANES)
   ) UUT (
      .clk    (clk),
      .rst    (rst),
      .cmd    (cmd),
      .result (result)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   // Rising edges seen so far
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   // ====================
   // Reference model
   // ====================

   // Full-width sum, then keep the low DATA_W bits
   function automatic logic [DATA_W-1:0] row_score(input int r, input vec_t act);
      logic [47:0] acc;
      acc = '0;
      for (int k = 0; k < VEC_N; k++) begin
         acc = acc + 48'(model_w[r][k]) * 48'(act[k]);
      end
      return acc[DATA_W-1:0];
   endfunction

   task automatic push_expected(input vec_t act);
      exp_result_t       e;
      logic [DATA_W-1:0] s;
      e     = '0;
      e.cyc = cycle_cnt;
      for (int r = 0; r < LANES; r++) begin
         s = row_score(r, act);
         // Strictly greater, so an earlier row keeps a tie
         if (r == 0 || s > e.score) begin
            e.score = s;
            e.index = ROW_W'(r);
         end
      end
      exp_q.push_back(e);
   endtask

   function automatic vec_t random_vector();
      vec_t v;
      for (int k = 0; k < VEC_N; k++) begin
         v[k] = DATA_W'($urandom());
      end
      return v;
   endfunction

   // ====================
   // Command drivers
   // ====================

   // One command per falling edge, model updated alongside
   task automatic send_cmd(input logic strobe, input opcode_e op,
                           input logic [ROW_W-1:0] row, input vec_t data);
      int ri;
      ri = int'(row);
      @(negedge clk);
      cmd.valid = strobe;
      cmd.op    = op;
      cmd.row   = row;
      cmd.data  = data;
      // Rows past the last lane are dropped by the DUT
      if (strobe && op == OP_LOAD && ri < LANES) begin
         model_w[ri] = data;
      end
      if (strobe && op == OP_RUN) begin
         push_expected(data);
      end
   endtask

   task automatic load_row(input logic [ROW_W-1:0] row, input vec_t w);
      send_cmd(1'b1, OP_LOAD, row, w);
   endtask

   task automatic run_vector(input vec_t act);
      send_cmd(1'b1, OP_RUN, '0, act);
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(negedge clk);
         cmd = '0;
      end
   endtask

   // Outstanding runs drain, watchdog bounds the wait
   task automatic wait_drain();
      @(negedge clk);
      cmd = '0;
      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
   endtask

   // ====================
   // Result monitor
   // ====================

   always @(posedge clk) begin
      if (!rst && result.valid) begin
         have_exp = (exp_q.size() != 0);
         if (have_exp) begin
            head = exp_q.pop_front();
         end else begin
            head = '0;
         end
         lat = cycle_cnt - head.cyc;
         assert (have_exp && result.index == head.index &&
                 result.score == head.score && lat == LATENCY)
         else begin
            if (!have_exp) begin
               $display("Result at time %0t arrived with no run outstanding", $time);
            end else if (result.index != head.index) begin
               $display("Fail at %0t: result.index expected %0d got %0d",
                        $time, head.index, result.index);
            end else if (result.score != head.score) begin
               $display("Fail at %0t: result.score expected %0h got %0h",
                        $time, head.score, result.score);
            end else begin
               $display("Result at time %0t came %0d cycles after its run, not %0d",
                        $time, lat, LATENCY);
            end
            $display("*** TEST FAILED ***");
            $fatal(1, "Result check failed");
         end
      end
   end

   // ====================
   // Directed tests
   // ====================

   // All weights zero, so row 0 wins with score 0
   task automatic reset_state_run();
      idle(8);
      run_vector(random_vector());
      wait_drain();
   endtask

   task automatic basic_score();
      vec_t w;
      for (int r = 0; r < LANES; r++) begin
         w[0] = DATA_W'(r + 1);
         w[1] = DATA_W'((r * 3) % 8);
         w[2] = DATA_W'(7 - r);
         w[3] = DATA_W'(5);
         load_row(ROW_W'(r), w);
      end
      run_vector({16'd1, 16'd2, 16'd3, 16'd4});
      wait_drain();
   endtask

   // Full-range operands wrap modulo 2^16
   task automatic overflow_wrap();
      for (int r = 0; r < LANES; r++) begin
         load_row(ROW_W'(r), random_vector());
      end
      repeat (4) run_vector(random_vector());
      wait_drain();
   endtask

   task automatic tie_break();
      // Every row equal
      for (int r = 0; r < LANES; r++) begin
         load_row(ROW_W'(r), {16'd40, 16'd30, 16'd20, 16'd10});
      end
      run_vector({16'd4, 16'd3, 16'd2, 16'd1});
      wait_drain();
      // Rows 2, 5 and 6 share the top score
      for (int r = 0; r < LANES; r++) begin
         if (r == 2 || r == 5 || r == 6) begin
            load_row(ROW_W'(r), {16'd90, 16'd70, 16'd50, 16'd30});
         end else begin
            load_row(ROW_W'(r), {16'd1, 16'd1, 16'd1, 16'd1});
         end
      end
      run_vector({16'd4, 16'd3, 16'd2, 16'd1});
      run_vector({16'd1, 16'd1, 16'd1, 16'd1});
      wait_drain();
   endtask

   task automatic load_then_run();
      // Run on the very next cycle sees the new row
      load_row(4'd4, {16'd1000, 16'd1000, 16'd1000, 16'd1000});
      run_vector({16'd1, 16'd1, 16'd1, 16'd1});
      wait_drain();
      // Out-of-range rows would win if they aliased onto a lane
      load_row(4'd9, {16'd2000, 16'd2000, 16'd2000, 16'd2000});
      run_vector({16'd1, 16'd1, 16'd1, 16'd1});
      load_row(4'd15, {16'd3000, 16'd3000, 16'd3000, 16'd3000});
      run_vector({16'd1, 16'd1, 16'd1, 16'd1});
      wait_drain();
   endtask

   // Back-to-back runs, then a random mix of all commands
   task automatic random_stream();
      int               pick;
      logic             strobe;
      logic [ROW_W-1:0] row;
      repeat (6) run_vector(random_vector());
      wait_drain();
      repeat (STREAM_N) begin
         pick   = $urandom_range(0, 9);
         strobe = ($urandom_range(0, 7) != 0);
         row    = ROW_W'($urandom_range(0, 15));
         if (pick < 2) begin
            send_cmd(strobe, OP_NOP, row, random_vector());
         end else if (pick < 5) begin
            send_cmd(strobe, OP_LOAD, row, random_vector());
         end else begin
            send_cmd(strobe, OP_RUN, row, random_vector());
         end
      end
   endtask

   // ====================
   // Main sequence
   // ====================

   initial begin
      void'($urandom(32'he9cefeb8));
      rst = 1'b1;
      cmd = '0;
      for (int r = 0; r < LANES; r++) begin
         model_w[r] = '0;
      end
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      reset_state_run();
      basic_score();
      overflow_wrap();
      tie_break();
      load_then_run();
      random_stream();
      // Last runs of the stream come out within these idle cycles
      idle(10);

      if (exp_q.size() != 0) begin
         $display("%0d expected results never arrived", exp_q.size());
         $display("*** TEST FAILED ***");
         $fatal(1, "Missing results");
      end else begin
         $display("*** TEST PASSED ***");
         $finish;
      end
   end

   // Watchdog sized from the command count
   initial begin
      #((STREAM_N + DIRECTED_N + MARGIN) * CLK_PERIOD);
      $display("Watchdog expired at time %0t with %0d results outstanding",
               $time, exp_q.size());
      $display("*** TEST FAILED ***");
      $fatal(1, "Timeout");
   end

endmodule

`default_nettype wire

// ==== bench/mv_score_sva.sv ====
// Concurrent assertions for the scoring engine top level
// Reset behavior, run-to-result latency, lane lockstep
// Bound into every mv_score_top instance

`timescale 1ns/100ps
`default_nettype none

module mv_score_sva #(
   parameter int LANES = 8
) (
   input logic            clk,
   input logic            rst,
   input mv_pkg::cmd_t    cmd,
   input mv_pkg::result_t result,
   input logic            score_valid [LANES]
);

   import mv_pkg::*;

   // Edge that samples a run to result.valid high
   localparam int LATENCY = 6;

   // Run strobe as the feeder decodes it
   logic run;

   assign run = cmd.valid && (cmd.op == OP_RUN);

   // ====================
   // Reset
   // ====================

   // No result while reset is held
   a_reset_low: assert property (@(posedge clk) rst |-> !result.valid)
      else $error("result.valid high during reset");

   // Nor on the edge right after
   a_reset_after: assert property (@(posedge clk) rst |=> !result.valid)
      else $error("result.valid high right after reset");

   // ====================
   // Latency
   // ====================

   // One result per run, exactly LATENCY edges later
   a_latency: assert property (@(posedge clk) disable iff (rst)
      result.valid == $past(run, LATENCY))
      else $error("result.valid does not match the run strobe %0d cycles back", LATENCY);

   // ====================
   // Lockstep
   // ====================

   // Argmax trusts lane 0 for every lane
   generate
      for (genvar l = 1; l < LANES; l++) begin : g_lockstep
         a_lockstep: assert property (@(posedge clk) disable iff (rst)
            score_valid[l] == score_valid[0])
            else $error("Lane %0d score_valid differs from lane 0", l);
      end
   endgenerate

endmodule

bind mv_score_top mv_score_sva #(
   .LANES       (LANES)
) u_sva (
   .clk         (clk),
   .rst         (rst),
   .cmd         (cmd),
   .result      (result),
   .score_valid (score_valid)
);

`default_nettype wire

// ==== src/mv_score_top.sv ====
// Top level of the matrix-vector scoring engine
// Weight feeder, one dot product lane per row, argmax stage
// Six cycles from a sampled run to the result

`timescale 1ns/100ps
`default_nettype none

module mv_score_top #(
   parameter int LANES = 8
) (
   input  logic            clk,
   input  logic            rst,
   input  mv_pkg::cmd_t    cmd,
   output mv_pkg::result_t result
);

   import mv_pkg::*;

   // Operand sets from the feeder, one per row
   lane_in_t          lane_in     [LANES];

   // Lane results into the argmax
   logic [DATA_W-1:0] score       [LANES];
   logic              score_valid [LANES];

   // ====================
   // Feeder
   // ====================

   weight_feeder #(
      .LANES   (LANES)
   ) u_feeder (
      .clk     (clk),
      .rst     (rst),
      .cmd     (cmd),
      .lane_in (lane_in)
   );

   // ====================
   // Lanes
   // ====================

   // One lane per weight row
   generate
      for (genvar g = 0; g < LANES; g++) begin : g_lane
         dot_lane u_lane (
            .clk         (clk),
            .rst         (rst),
            .lane_in     (lane_in[g]),
            .score       (score[g]),
            .score_valid (score_valid[g])
         );
      end
   endgenerate

   // ====================
   // Argmax
   // ====================

   score_argmax #(
      .LANES       (LANES)
   ) u_argmax (
      .clk         (clk),
      .rst         (rst),
      .score       (score),
      .score_valid (score_valid),
      .result      (result)
   );

endmodule

`default_nettype wire

// ==== src/score_argmax.sv ====
// Argmax over the lane scores
// Unsigned comparison tree, lower index wins a tie
// Registers the winning row index and score

`timescale 1ns/100ps
`default_nettype none

module score_argmax #(
   parameter int LANES = 8
) (
   input  logic                      clk,
   input  logic                      rst,
   input  logic [mv_pkg::DATA_W-1:0] score [LANES],
   input  logic                      score_valid [LANES],
   output mv_pkg::result_t           result
);

   import mv_pkg::*;

   // Leaves padded up to a power of two
   localparam int NODES = 1 << $clog2(LANES);

   // ====================
   // Comparison tree
   // ====================

   // Heap layout: node n has children 2n+1 and 2n+2
   // Leaves sit at NODES-1 and up, left child always holds lower indices
   logic [DATA_W-1:0] node_score [2*NODES-1];
   logic [ROW_W-1:0]  node_idx   [2*NODES-1];

   result_t result_r;

   generate
      for (genvar j = 0; j < NODES; j++) begin : g_leaf
         if (j < LANES) begin : g_real
            assign node_score[NODES-1+j] = score[j];
         end else begin : g_pad
            // Score 0 at a high index never beats a real lane
            assign node_score[NODES-1+j] = '0;
         end
         assign node_idx[NODES-1+j] = ROW_W'(j);
      end

      for (genvar n = 0; n < NODES-1; n++) begin : g_node
         logic keep_left;
         // Greater or equal keeps the left, giving lowest index on ties
         assign keep_left = (node_score[2*n+1] >= node_score[2*n+2]);
         assign node_score[n] = keep_left ? node_score[2*n+1] : node_score[2*n+2];
         assign node_idx[n]   = keep_left ? node_idx[2*n+1]   : node_idx[2*n+2];
      end
   endgenerate

   // ====================
   // Output register
   // ====================

   // All lanes run in lockstep, so lane 0 stands for the rest
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         result_r <= '0;
      end else begin
         result_r.valid <= score_valid[0];
         if (score_valid[0]) begin
            result_r.index <= node_idx[0];
            result_r.score <= node_score[0];
         end
      end
   end

   assign result = result_r;

endmodule

`default_nettype wire

// ==== src/dot_lane.sv ====
// Per-row dot product lane
// Input register, pairwise multiply, two-level adder tree, output register
// Arithmetic wraps modulo 2^DATA_W at every stage

`timescale 1ns/100ps
`default_nettype none

module dot_lane (
   input  logic                      clk,
   input  logic                      rst,
   input  mv_pkg::lane_in_t          lane_in,
   output logic [mv_pkg::DATA_W-1:0] score,
   output logic                      score_valid
);

   import mv_pkg::*;

   // Cycles from lane_in.valid to score_valid
   localparam int LATENCY = 4;

   // Adders in the first tree level
   localparam int SUMS = VEC_N / 2;

   // ====================
   // Pipeline registers
   // ====================

   logic [DATA_W-1:0]  in_r   [2*VEC_N];
   logic [DATA_W-1:0]  mult_r [VEC_N];
   logic [DATA_W-1:0]  add_r  [SUMS];
   logic [DATA_W-1:0]  out_r;
   logic [LATENCY-1:0] valid_r;

   // Datapath, one register per stage
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < 2*VEC_N; i++) begin
            in_r[i] <= '0;
         end
         for (int i = 0; i < VEC_N; i++) begin
            mult_r[i] <= '0;
         end
         for (int i = 0; i < SUMS; i++) begin
            add_r[i] <= '0;
         end
         out_r <= '0;
      end else begin
         // Stage 1: capture operands
         for (int i = 0; i < 2*VEC_N; i++) begin
            in_r[i] <= lane_in.opnd[i];
         end
         // Stage 2: weight times activation, upper half dropped
         for (int i = 0; i < VEC_N; i++) begin
            mult_r[i] <= in_r[2*i] * in_r[2*i+1];
         end
         // Stage 3: first adder level
         for (int i = 0; i < SUMS; i++) begin
            add_r[i] <= mult_r[2*i] + mult_r[2*i+1];
         end
         // Stage 4: final adder
         out_r <= add_r[0] + add_r[1];
      end
   end

   // Valid delay line, bit 0 is the youngest
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_r <= '0;
      end else begin
         valid_r <= {valid_r[LATENCY-2:0], lane_in.valid};
      end
   end

   assign score       = out_r;
   assign score_valid = valid_r[LATENCY-1];

endmodule

`default_nettype wire

// ==== src/weight_feeder.sv ====
// Command decoder and weight bank
// Stores one weight row per lane on a load
// On a run, registers each lane's weights interleaved with the activations

`timescale 1ns/100ps
`default_nettype none

module weight_feeder #(
   parameter int LANES = 8
) (
   input  logic              clk,
   input  logic              rst,
   input  mv_pkg::cmd_t      cmd,
   output mv_pkg::lane_in_t  lane_in [LANES]
);

   import mv_pkg::*;

   // ====================
   // Storage
   // ====================

   // One row of VEC_N weights per lane
   logic [VEC_N-1:0][DATA_W-1:0] weights [LANES];

   // Registered operand sets, one per lane
   lane_in_t lane_r [LANES];

   // Decoded command strobes
   logic load;
   logic run;

   // ====================
   // Decode
   // ====================

   // A low strobe or a NOP leaves everything alone
   assign load = cmd.valid && (cmd.op == OP_LOAD);
   assign run  = cmd.valid && (cmd.op == OP_RUN);

   // ====================
   // Weight bank
   // ====================

   // Row compare per lane, so rows at or above LANES never match
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int r = 0; r < LANES; r++) begin
            weights[r] <= '0;
         end
      end else if (load) begin
         for (int r = 0; r < LANES; r++) begin
            if (cmd.row == ROW_W'(r)) begin
               weights[r] <= cmd.data;
            end
         end
      end
   end

   // ====================
   // Operand registers
   // ====================

   // Weights read here are the values before this edge
   // A load sampled on the same edge is not yet visible
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int l = 0; l < LANES; l++) begin
            lane_r[l] <= '0;
         end
      end else begin
         for (int l = 0; l < LANES; l++) begin
            // Valid is a one-cycle pulse per run
            lane_r[l].valid <= run;
            if (run) begin
               for (int k = 0; k < VEC_N; k++) begin
                  // Weight in the even slot, activation next to it
                  lane_r[l].opnd[2*k]   <= weights[l][k];
                  lane_r[l].opnd[2*k+1] <= cmd.data[k];
               end
            end
         end
      end
   end

   // Drive the lanes from the registers
   always_comb begin
      for (int l = 0; l < LANES; l++) begin
         lane_in[l] = lane_r[l];
      end
   end

endmodule

`default_nettype wire

// ==== src/mv_pkg.sv ====
// Shared definitions for the matrix-vector scoring engine
// Data width, vector length and row index width
// Command opcodes and the packed structs of the datapath

`default_nettype none

package mv_pkg;

   // ====================
   // Sizes
   // ====================

   // Width of weights, activations, products and scores
   localparam int DATA_W = 16;

   // Elements per activation vector and per weight row
   localparam int VEC_N = 4;

   // Row index width, so at most 16 rows
   localparam int ROW_W = 4;

   // ====================
   // Commands
   // ====================

   // Command codes carried with every strobe
   typedef enum logic [1:0] {
      OP_NOP  = 2'd0,
      OP_LOAD = 2'd1,
      OP_RUN  = 2'd2
   } opcode_e;

   // One command from outside
   // Row is only meaningful for a load
   // Data holds weights for a load, activations for a run
   typedef struct packed {
      logic                         valid;
      opcode_e                      op;
      logic [ROW_W-1:0]             row;
      logic [VEC_N-1:0][DATA_W-1:0] data;
   } cmd_t;

   // ====================
   // Datapath
   // ====================

   // Operands for one lane
   // Even slots hold weights, odd slots the matching activation
   typedef struct packed {
      logic                           valid;
      logic [2*VEC_N-1:0][DATA_W-1:0] opnd;
   } lane_in_t;

   // Winning row and its score
   typedef struct packed {
      logic              valid;
      logic [ROW_W-1:0]  index;
      logic [DATA_W-1:0] score;
   } result_t;

endpackage

`default_nettype wire
